//--- list.f
+incdir+src
src/mpx_audio_pkg.sv
src/mpx_ctrl_pkg.sv
src/mpx_regs.sv
src/mpx_channel_select.sv
src/pilot_dds.sv
src/mpx_combiner.sv
src/stereo_mpx.sv
testbench/tb_stereo_mpx.sv

//--- src/mpx_audio_pkg.sv
`include "mpx_settings.svh"

package mpx_audio_pkg;

    typedef logic signed [`MPX_SAMPLE_W-1:0] sample_t;
    typedef logic signed [`MPX_PILOT_W-1:0] pilot_t;
    typedef logic [`MPX_PHASE_W-1:0] phase_t;
    typedef logic [`MPX_GAIN_W-1:0] gain_t;

    // one full period, round(127 * sin(2*pi*k/32)).
    localparam pilot_t pilot_sine_table [`MPX_TABLE_SIZE] = '{
        8'sd0, 8'sd25, 8'sd49, 8'sd71,
        8'sd90, 8'sd106, 8'sd117, 8'sd125,
        8'sd127, 8'sd125, 8'sd117, 8'sd106,
        8'sd90, 8'sd71, 8'sd49, 8'sd25,
        8'sd0, -8'sd25, -8'sd49, -8'sd71,
        -8'sd90, -8'sd106, -8'sd117, -8'sd125,
        -8'sd127, -8'sd125, -8'sd117, -8'sd106,
        -8'sd90, -8'sd71, -8'sd49, -8'sd25
    };

endpackage

//--- src/mpx_channel_select.sv
`timescale 1ns/1ps

module mpx_channel_select
    import mpx_audio_pkg::*, mpx_ctrl_pkg::*;
(
    input  logic        mclk,
    input  logic        mreset,
    input  sample_t     in_l,
    input  sample_t     in_r,
    input  logic        in_valid,
    input  logic        in_valid_180,
    input  sample_t     pbka_l,
    input  sample_t     pbka_r,
    input  logic        pbka_valid,
    input  logic        pbka_valid_180,
    input  logic        mpx_sel,
    input  source_sel_t source_sel,
    output logic        sample_strobe,
    output sample_t     mix,
    output logic        mix_valid
);

    sample_t src_l;
    sample_t src_r;
    sample_t pick_q;
    logic    strobe_q;

    // a muted source passes no samples and no strobes.
    always_comb begin
        src_l = '0;
        src_r = '0;
        sample_strobe = 1'b0;
        case (source_sel)
            SRC_LIVE: begin
                src_l = in_l;
                src_r = in_r;
                sample_strobe = in_valid | in_valid_180;
            end
            SRC_PLAYBACK: begin
                src_l = pbka_l;
                src_r = pbka_r;
                sample_strobe = pbka_valid | pbka_valid_180;
            end
            SRC_MUTE, SRC_MUTE_ALT: begin
                sample_strobe = 1'b0;
            end
        endcase
    end

    // capture stage.
    always_ff @(posedge mclk) begin
        if (sample_strobe) begin
            pick_q <= mpx_sel ? src_l : src_r;
        end
    end

    // second stage lines the sample up with the scaled pilot.
    always_ff @(posedge mclk) begin
        if (strobe_q) begin
            mix <= pick_q;
        end
    end

    always_ff @(posedge mclk) begin
        if (mreset) begin
            strobe_q <= 1'b0;
            mix_valid <= 1'b0;
        end else begin
            strobe_q <= sample_strobe;
            mix_valid <= strobe_q;
        end
    end

endmodule

//--- src/mpx_combiner.sv
`timescale 1ns/1ps
`include "mpx_settings.svh"

module mpx_combiner
    import mpx_audio_pkg::*, mpx_ctrl_pkg::*;
(
    input  logic        mclk,
    input  logic        mreset,
    input  sample_t     mix,
    input  logic        mix_valid,
    input  sample_t     scaled_pilot,
    input  logic        stat_clear,
    input  logic        stat_enable,
    input  stat_count_t stat_limit,
    output sample_t     mpx_out,
    output logic        mpx_valid,
    output stat_byte_t  stat_min,
    output stat_byte_t  stat_max,
    output stat_count_t stat_count
);

    logic signed [`MPX_SAMPLE_W:0] sum;
    sample_t                       sum_sat;
    stat_byte_t                    out_byte;

    assign sum = mix + scaled_pilot;

    // overflow shows as a mismatch of the two top bits.
    always_comb begin
        if (sum[`MPX_SAMPLE_W] != sum[`MPX_SAMPLE_W-1]) begin
            sum_sat = {sum[`MPX_SAMPLE_W], {(`MPX_SAMPLE_W-1){~sum[`MPX_SAMPLE_W]}}};
        end else begin
            sum_sat = sum[`MPX_SAMPLE_W-1:0];
        end
    end

    always_ff @(posedge mclk) begin
        if (mreset) begin
            mpx_out <= '0;
            mpx_valid <= 1'b0;
        end else begin
            mpx_valid <= mix_valid;
            if (mix_valid) begin
                mpx_out <= sum_sat;
            end
        end
    end

    assign out_byte = mpx_out[`MPX_SAMPLE_W-1 -: $bits(stat_byte_t)];

    // statistics lag the output by one cycle.
    always_ff @(posedge mclk) begin
        if (mreset || stat_clear) begin
            stat_min <= stat_byte_t'(`MPX_STAT_MIN_RESET);
            stat_max <= stat_byte_t'(`MPX_STAT_MAX_RESET);
            stat_count <= '0;
        end else if (mpx_valid && stat_enable && (stat_count < stat_limit)) begin
            if (out_byte < stat_min) begin
                stat_min <= out_byte;
            end
            if (out_byte > stat_max) begin
                stat_max <= out_byte;
            end
            stat_count <= stat_count + 1'b1;
        end
    end

endmodule

//--- src/mpx_ctrl_pkg.sv
`include "mpx_settings.svh"

package mpx_ctrl_pkg;

    // register bus words.
    typedef logic [`MPX_BUS_W-1:0] bus_addr_t;
    typedef logic [`MPX_BUS_W-1:0] bus_data_t;

    // sample source; both mute codes give silence.
    typedef enum logic [1:0] {
        SRC_LIVE = 2'd0,
        SRC_PLAYBACK = 2'd1,
        SRC_MUTE = 2'd2,
        SRC_MUTE_ALT = 2'd3
    } source_sel_t;

    // statistics track the upper byte of each output sample.
    typedef logic signed [7:0] stat_byte_t;
    typedef logic [`MPX_COUNT_W-1:0] stat_count_t;

endpackage

//--- src/mpx_regs.sv
`timescale 1ns/1ps
`include "mpx_settings.svh"

module mpx_regs
    import mpx_audio_pkg::*, mpx_ctrl_pkg::*;
(
    input  logic        mclk,
    input  logic        mreset,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  bus_addr_t   paddr,
    input  bus_data_t   pwdata,
    output bus_data_t   prdata,
    output source_sel_t source_sel,
    output gain_t       pilot_gain,
    output phase_t      pilot_step,
    output logic        stat_clear,
    output logic        stat_enable,
    output stat_count_t stat_limit,
    input  stat_byte_t  stat_min,
    input  stat_byte_t  stat_max,
    input  stat_count_t stat_count
);

    logic wr_en;

    // access phase of a write.
    assign wr_en = psel & penable & pwrite;

    always_ff @(posedge mclk) begin
        if (mreset) begin
            source_sel <= SRC_LIVE;
            pilot_gain <= '0;
            pilot_step <= '0;
            stat_clear <= 1'b0;
            stat_enable <= 1'b0;
            stat_limit <= `MPX_STAT_LIMIT_RESET;
        end else if (wr_en) begin
            case (paddr)
                `MPX_ADDR_CTRL: begin
                    source_sel <= source_sel_t'(pwdata[1:0]);
                end
                `MPX_ADDR_GAIN: begin
                    pilot_gain <= pwdata[`MPX_GAIN_W-1:0];
                end
                `MPX_ADDR_STEP: begin
                    pilot_step <= pwdata[`MPX_PHASE_W-1:0];
                end
                `MPX_ADDR_STAT_CFG: begin
                    stat_clear <= pwdata[0];
                    stat_enable <= pwdata[1];
                end
                `MPX_ADDR_STAT_LIMIT: begin
                    stat_limit <= pwdata[`MPX_COUNT_W-1:0];
                end
                default: begin
                end
            endcase
        end
    end

    // zero wait state read path, unmapped offsets return zero.
    always_comb begin
        prdata = '0;
        case (paddr)
            `MPX_ADDR_CTRL: prdata[1:0] = source_sel;
            `MPX_ADDR_GAIN: prdata[`MPX_GAIN_W-1:0] = pilot_gain;
            `MPX_ADDR_STEP: prdata[`MPX_PHASE_W-1:0] = pilot_step;
            `MPX_ADDR_STAT_CFG: prdata[1:0] = {stat_enable, stat_clear};
            `MPX_ADDR_STAT_LIMIT: prdata[`MPX_COUNT_W-1:0] = stat_limit;
            `MPX_ADDR_STAT_RANGE: prdata = {{16{stat_max[7]}}, stat_max, stat_min};
            `MPX_ADDR_STAT_COUNT: prdata[`MPX_COUNT_W-1:0] = stat_count;
            default: prdata = '0;
        endcase
    end

endmodule

//--- src/mpx_settings.svh
`ifndef MPX_SETTINGS_SVH
`define MPX_SETTINGS_SVH

// audio datapath widths.
`define MPX_SAMPLE_W 16
`define MPX_PILOT_W 8

// pilot gain is unsigned with 8 fraction bits.
`define MPX_GAIN_W 16
`define MPX_GAIN_FRAC 8

`define MPX_PHASE_W 32
`define MPX_TABLE_BITS 5
`define MPX_TABLE_SIZE (1 << `MPX_TABLE_BITS)

`define MPX_BUS_W 32
`define MPX_COUNT_W 32

// register byte offsets.
`define MPX_ADDR_CTRL 32'h00
`define MPX_ADDR_GAIN 32'h04
`define MPX_ADDR_STEP 32'h08
`define MPX_ADDR_STAT_CFG 32'h0C
`define MPX_ADDR_STAT_LIMIT 32'h10
`define MPX_ADDR_STAT_RANGE 32'h14
`define MPX_ADDR_STAT_COUNT 32'h18

// statistics start values.
`define MPX_STAT_MIN_RESET 127
`define MPX_STAT_MAX_RESET (-128)
`define MPX_STAT_LIMIT_RESET 32'hFFFF_FFFF

`endif

//--- src/pilot_dds.sv
`timescale 1ns/1ps
`include "mpx_settings.svh"

module pilot_dds
    import mpx_audio_pkg::*;
(
    input  logic    mclk,
    input  logic    mreset,
    input  logic    sample_strobe,
    input  phase_t  pilot_step,
    input  gain_t   pilot_gain,
    output sample_t scaled_pilot
);

    localparam int PROD_W = `MPX_PILOT_W + `MPX_GAIN_W + 1;
    localparam int SAT_MAX = (1 << (`MPX_SAMPLE_W - 1)) - 1;
    localparam int SAT_MIN = -(1 << (`MPX_SAMPLE_W - 1));

    phase_t                    phase;
    pilot_t                    entry_q;
    logic                      strobe_q;
    logic signed [PROD_W-1:0]  product;
    logic signed [PROD_W-1:0]  shifted;
    sample_t                   clamped;

    // lookup uses the phase before this strobe's step.
    always_ff @(posedge mclk) begin
        if (mreset) begin
            phase <= '0;
            strobe_q <= 1'b0;
        end else begin
            strobe_q <= sample_strobe;
            if (sample_strobe) begin
                phase <= phase + pilot_step;
            end
        end
    end

    always_ff @(posedge mclk) begin
        if (sample_strobe) begin
            entry_q <= pilot_sine_table[phase[`MPX_PHASE_W-1 -: `MPX_TABLE_BITS]];
        end
    end

    // gain is unsigned, so widen it by a zero bit before the signed multiply.
    assign product = entry_q * $signed({1'b0, pilot_gain});
    assign shifted = product >>> `MPX_GAIN_FRAC;

    always_comb begin
        if (shifted > SAT_MAX) begin
            clamped = sample_t'(SAT_MAX);
        end else if (shifted < SAT_MIN) begin
            clamped = sample_t'(SAT_MIN);
        end else begin
            clamped = shifted[`MPX_SAMPLE_W-1:0];
        end
    end

    // holds between strobes.
    always_ff @(posedge mclk) begin
        if (strobe_q) begin
            scaled_pilot <= clamped;
        end
    end

endmodule

//--- src/stereo_mpx.sv
`timescale 1ns/1ps

module stereo_mpx
    import mpx_audio_pkg::*, mpx_ctrl_pkg::*;
(
    input  logic      mclk,
    input  logic      mreset,
    input  logic      psel,
    input  logic      penable,
    input  bus_addr_t paddr,
    input  logic      pwrite,
    input  bus_data_t pwdata,
    output bus_data_t prdata,
    input  sample_t   in_l,
    input  sample_t   in_r,
    input  logic      in_valid,
    input  logic      in_valid_180,
    input  sample_t   pbka_l,
    input  sample_t   pbka_r,
    input  logic      pbka_valid,
    input  logic      pbka_valid_180,
    input  logic      mpx_sel,
    output sample_t   mpx_out,
    output logic      mpx_valid
);

    source_sel_t source_sel;
    gain_t       pilot_gain;
    phase_t      pilot_step;
    logic        stat_clear;
    logic        stat_enable;
    stat_count_t stat_limit;
    stat_byte_t  stat_min;
    stat_byte_t  stat_max;
    stat_count_t stat_count;
    logic        sample_strobe;
    sample_t     mix;
    logic        mix_valid;
    sample_t     scaled_pilot;

    mpx_regs u_regs (
        .mclk        (mclk),
        .mreset      (mreset),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .source_sel  (source_sel),
        .pilot_gain  (pilot_gain),
        .pilot_step  (pilot_step),
        .stat_clear  (stat_clear),
        .stat_enable (stat_enable),
        .stat_limit  (stat_limit),
        .stat_min    (stat_min),
        .stat_max    (stat_max),
        .stat_count  (stat_count)
    );

    mpx_channel_select u_channel_select (
        .mclk           (mclk),
        .mreset         (mreset),
        .in_l           (in_l),
        .in_r           (in_r),
        .in_valid       (in_valid),
        .in_valid_180   (in_valid_180),
        .pbka_l         (pbka_l),
        .pbka_r         (pbka_r),
        .pbka_valid     (pbka_valid),
        .pbka_valid_180 (pbka_valid_180),
        .mpx_sel        (mpx_sel),
        .source_sel     (source_sel),
        .sample_strobe  (sample_strobe),
        .mix            (mix),
        .mix_valid      (mix_valid)
    );

    pilot_dds u_pilot_dds (
        .mclk          (mclk),
        .mreset        (mreset),
        .sample_strobe (sample_strobe),
        .pilot_step    (pilot_step),
        .pilot_gain    (pilot_gain),
        .scaled_pilot  (scaled_pilot)
    );

    mpx_combiner u_combiner (
        .mclk         (mclk),
        .mreset       (mreset),
        .mix          (mix),
        .mix_valid    (mix_valid),
        .scaled_pilot (scaled_pilot),
        .stat_clear   (stat_clear),
        .stat_enable  (stat_enable),
        .stat_limit   (stat_limit),
        .mpx_out      (mpx_out),
        .mpx_valid    (mpx_valid),
        .stat_min     (stat_min),
        .stat_max     (stat_max),
        .stat_count   (stat_count)
    );

endmodule

//--- testbench/tb_stereo_mpx.sv
`timescale 1ns/1ps
`include "mpx_settings.svh"

module tb_stereo_mpx
    import mpx_audio_pkg::*, mpx_ctrl_pkg::*;
();

    localparam int N_LIVE = 200;
    localparam int N_PBK = 100;
    localparam int N_MUTE = 40;
    localparam int N_PILOT = 150;
    localparam int N_SAT = 100;
    localparam int N_STAT = 60;
    localparam int N_LIMIT = 40;
    localparam int STIM_CYCLES = N_LIVE + N_PBK + 2 * N_MUTE + N_PILOT + N_SAT + N_STAT + N_LIMIT;
    // bus accesses and pipeline drains fit well inside the margin.
    localparam int MAX_CYCLES = 2 * STIM_CYCLES + 1000;

    logic      mclk = 1'b0;
    logic      mreset;
    logic      psel;
    logic      penable;
    logic      pwrite;
    bus_addr_t paddr;
    bus_data_t pwdata;
    bus_data_t prdata;
    sample_t   in_l;
    sample_t   in_r;
    sample_t   pbka_l;
    sample_t   pbka_r;
    logic      in_valid;
    logic      in_valid_180;
    logic      pbka_valid;
    logic      pbka_valid_180;
    logic      mpx_sel;
    sample_t   mpx_out;
    logic      mpx_valid;

    // model state.
    logic [31:0] lcg_state = 32'd80505;
    phase_t      model_phase = '0;
    phase_t      model_step = '0;
    gain_t       model_gain = '0;
    int          model_src = 0;
    logic        m_stat_en = 1'b0;
    stat_count_t m_limit = `MPX_STAT_LIMIT_RESET;
    stat_count_t m_count = '0;
    stat_byte_t  m_min = 8'sd127;
    stat_byte_t  m_max = -8'sd128;
    sample_t     exp_q[$];
    int          cyc_q[$];
    int          cycle = 0;
    int          errors = 0;
    int          checks = 0;
    string       test_name = "reset";

    stereo_mpx DUT (
        .mclk(mclk), .mreset(mreset), .psel(psel), .penable(penable),
        .paddr(paddr), .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata),
        .in_l(in_l), .in_r(in_r), .in_valid(in_valid), .in_valid_180(in_valid_180),
        .pbka_l(pbka_l), .pbka_r(pbka_r), .pbka_valid(pbka_valid),
        .pbka_valid_180(pbka_valid_180), .mpx_sel(mpx_sel),
        .mpx_out(mpx_out), .mpx_valid(mpx_valid)
    );

    initial begin
        forever #5 mclk = ~mclk;
    end

    function automatic logic [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:15];
    endfunction

    function automatic int sat16(input int v);
        if (v > 32767) begin
            return 32767;
        end else if (v < -32768) begin
            return -32768;
        end
        return v;
    endfunction

    // expected output from the datapath rules.
    function automatic sample_t ref_mpx(input sample_t l, input sample_t r, input pilot_t entry,
                                        input gain_t gain, input logic sel);
        int pilot;
        int sum;
        pilot = sat16((int'(entry) * int'({1'b0, gain})) >>> 8);
        sum = (sel ? int'(l) : int'(r)) + pilot;
        return sample_t'(sat16(sum));
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Error %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic bus_write(input bus_addr_t addr, input bus_data_t data);
        psel = 1'b1;
        pwrite = 1'b1;
        paddr = addr;
        pwdata = data;
        @(negedge mclk);
        penable = 1'b1;
        @(negedge mclk);
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic read_and_check(input bus_addr_t addr, input bus_data_t expected);
        psel = 1'b1;
        paddr = addr;
        @(negedge mclk);
        penable = 1'b1;
        @(negedge mclk);
        check_value(test_name, expected, prdata);
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic set_src(input int src);
        bus_write(`MPX_ADDR_CTRL, src);
        model_src = src;
    endtask

    task automatic set_pilot(input phase_t step, input gain_t gain);
        bus_write(`MPX_ADDR_STEP, step);
        bus_write(`MPX_ADDR_GAIN, gain);
        model_step = step;
        model_gain = gain;
    endtask

    // clear wins over enable.
    task automatic set_stats(input logic [1:0] cfg);
        bus_write(`MPX_ADDR_STAT_CFG, cfg);
        m_stat_en = cfg[1] & ~cfg[0];
        if (cfg[0]) begin
            m_min = 8'sd127;
            m_max = -8'sd128;
            m_count = '0;
        end
    endtask

    task automatic check_stats();
        read_and_check(`MPX_ADDR_STAT_RANGE, {{16{m_max[7]}}, m_max, m_min});
        read_and_check(`MPX_ADDR_STAT_COUNT, m_count);
    endtask

    task automatic queue_event(input sample_t l, input sample_t r, input logic sel);
        sample_t    e;
        stat_byte_t b;
        e = ref_mpx(l, r, pilot_sine_table[model_phase[31 -: 5]], model_gain, sel);
        model_phase = model_phase + model_step;
        exp_q.push_back(e);
        cyc_q.push_back(cycle + 3);
        b = e[15:8];
        if (m_stat_en && m_count < m_limit) begin
            if (b < m_min) begin
                m_min = b;
            end
            if (b > m_max) begin
                m_max = b;
            end
            m_count++;
        end
    endtask

    // one cycle of stimulus on the live or the playback port.
    task automatic drive_cycle(input logic pbk, input logic v, input logic v180,
                               input sample_t l, input sample_t r, input logic sel);
        mpx_sel = sel;
        in_valid = !pbk && v;
        in_valid_180 = !pbk && v180;
        pbka_valid = pbk && v;
        pbka_valid_180 = pbk && v180;
        if (pbk) begin
            pbka_l = l;
            pbka_r = r;
        end else begin
            in_l = l;
            in_r = r;
        end
        if ((v || v180) && ((model_src == 0 && !pbk) || (model_src == 1 && pbk))) begin
            queue_event(l, r, sel);
        end
        @(negedge mclk);
    endtask

    // mode 0 live, 1 playback, 2 both at random.
    task automatic run_random(input int n, input int mode, input logic extreme);
        logic [15:0] r;
        sample_t     l;
        sample_t     rr;
        logic        pbk;
        repeat (n) begin
            r = lcg_next();
            l = sample_t'(lcg_next());
            rr = sample_t'(lcg_next());
            if (extreme && r[5]) begin
                l = r[6] ? 16'sh7FFF : 16'sh8000;
                rr = r[7] ? 16'sh7FFF : 16'sh8000;
            end
            pbk = (mode == 2) ? r[4] : mode[0];
            drive_cycle(pbk, r[0], r[1] & r[2], l, rr, r[3]);
        end
        drive_cycle(1'b0, 1'b0, 1'b0, '0, '0, 1'b0);
        while (exp_q.size() != 0) begin
            @(negedge mclk);
        end
        repeat (3) @(negedge mclk);
    endtask

    always @(negedge mclk) begin
        if (!mreset && mpx_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Error: mpx_valid with no expected sample in %s at cycle %0d",
                         test_name, cycle);
            end else begin
                check_value({test_name, " data"}, exp_q.pop_front(), mpx_out);
                check_value({test_name, " latency"}, cyc_q.pop_front(), cycle);
            end
        end
    end

    always @(posedge mclk) begin
        cycle <= cycle + 1;
        if (cycle > MAX_CYCLES) begin
            $display("Run stopped: cycle limit of %0d reached", MAX_CYCLES);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        mreset = 1'b1;
        {psel, penable, pwrite, paddr, pwdata} = '0;
        {in_l, in_r, pbka_l, pbka_r} = '0;
        {in_valid, in_valid_180, pbka_valid, pbka_valid_180, mpx_sel} = '0;
        repeat (5) @(negedge mclk);
        mreset = 1'b0;
        @(negedge mclk);
        check_value(test_name, 32'h0, mpx_out);
        check_value(test_name, 32'h0, mpx_valid);

        test_name = "regs";
        bus_write(`MPX_ADDR_CTRL, 32'h2);
        read_and_check(`MPX_ADDR_CTRL, 32'h2);
        bus_write(`MPX_ADDR_CTRL, 32'hFFFF_FFFD);
        read_and_check(`MPX_ADDR_CTRL, 32'h1);
        bus_write(`MPX_ADDR_GAIN, 32'h1234_ABCD);
        read_and_check(`MPX_ADDR_GAIN, 32'h0000_ABCD);
        bus_write(`MPX_ADDR_STEP, 32'hDEAD_BEEF);
        read_and_check(`MPX_ADDR_STEP, 32'hDEAD_BEEF);
        bus_write(`MPX_ADDR_STAT_CFG, 32'h1);
        read_and_check(`MPX_ADDR_STAT_CFG, 32'h1);
        bus_write(`MPX_ADDR_STAT_CFG, 32'hFFFF_FFFE);
        read_and_check(`MPX_ADDR_STAT_CFG, 32'h2);
        bus_write(`MPX_ADDR_STAT_LIMIT, 32'h1234_5678);
        read_and_check(`MPX_ADDR_STAT_LIMIT, 32'h1234_5678);
        read_and_check(32'h1C, 32'h0);
        read_and_check(32'h100, 32'h0);
        bus_write(`MPX_ADDR_STAT_LIMIT, `MPX_STAT_LIMIT_RESET);
        set_stats(2'b00);
        set_pilot('0, '0);
        set_src(0);

        test_name = "live";
        run_random(N_LIVE, 0, 1'b0);

        test_name = "playback";
        set_src(1);
        run_random(N_PBK, 2, 1'b0);
        test_name = "mute";
        set_src(2);
        run_random(N_MUTE, 2, 1'b0);
        set_src(3);
        run_random(N_MUTE, 2, 1'b0);
        set_src(0);

        test_name = "pilot";
        set_pilot(32'h0B40_0000, 16'h0180);
        run_random(N_PILOT, 0, 1'b0);
        test_name = "saturation";
        set_pilot(32'h1357_9BDF, 16'hFFFF);
        run_random(N_SAT, 0, 1'b1);

        test_name = "stats";
        set_stats(2'b01);
        set_stats(2'b10);
        run_random(N_STAT, 0, 1'b1);
        check_stats();
        test_name = "stat limit";
        bus_write(`MPX_ADDR_STAT_LIMIT, 32'd5);
        m_limit = 32'd5;
        set_stats(2'b01);
        set_stats(2'b10);
        run_random(N_LIMIT, 0, 1'b0);
        check_stats();
        test_name = "stat clear";
        set_stats(2'b01);
        repeat (2) @(negedge mclk);
        check_stats();

        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected samples never appeared at the output", exp_q.size());
        end
        $display("%0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
